//--- stream_pkg.sv
`default_nettype none

package stream_pkg;

  // Default widths, set again by the top level when it is instantiated.
  localparam int DATA_WIDTH_DEFAULT = 8;
  localparam int ADDR_WIDTH_DEFAULT = 4;  // 16 beats per queue.
  localparam int NUM_PORTS_DEFAULT = 4;

  localparam logic USER_BAD_FRAME = 1'b1;  // user value on a last beat that marks a bad frame.

  // Returns the width of a destination field for a given number of queues.
  function automatic int dest_width(input int num_ports);
    int width;
    width = $clog2(num_ports);
    if (width < 1) begin
      width = 1;  // a single queue still needs a one-bit field.
    end
    return width;
  endfunction

endpackage

`default_nettype wire

//--- frame_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module frame_fifo #(
  parameter int ADDR_WIDTH = stream_pkg::ADDR_WIDTH_DEFAULT,
  parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH_DEFAULT
) (
  input wire clk,
  input wire rst,
  input wire [DATA_WIDTH-1:0] s_data,
  input wire s_last,
  input wire s_user,
  input wire s_valid,
  output logic s_ready,
  output logic [DATA_WIDTH-1:0] q_data,
  output logic q_last,
  output logic q_valid,
  input wire q_ready,
  output logic status_overflow,
  output logic status_bad_frame,
  output logic status_good_frame
);

  import stream_pkg::*;

  localparam int WIDTH = DATA_WIDTH + 1;  // last sits above the data bits.
  localparam logic [ADDR_WIDTH:0] DEPTH = (ADDR_WIDTH+1)'(2**ADDR_WIDTH);

  logic [ADDR_WIDTH:0] wr_ptr_reg;
  logic [ADDR_WIDTH:0] wr_ptr_next;
  logic [ADDR_WIDTH:0] wr_ptr_cur_reg;
  logic [ADDR_WIDTH:0] wr_ptr_cur_next;
  logic [ADDR_WIDTH:0] wr_addr_reg;
  logic [ADDR_WIDTH:0] rd_ptr_reg;
  logic [ADDR_WIDTH:0] rd_ptr_next;
  logic [ADDR_WIDTH:0] rd_addr_reg;

  logic [WIDTH-1:0] mem [2**ADDR_WIDTH];
  logic [WIDTH-1:0] mem_read_data_reg;
  logic mem_read_data_valid_reg;
  logic mem_read_data_valid_next;
  logic [WIDTH-1:0] out_reg;
  logic out_valid_reg;
  logic out_valid_next;

  logic full_cur;
  logic empty;
  logic write;
  logic read;
  logic store_output;

  logic drop_frame_reg;
  logic drop_frame_next;
  logic overflow_reg;
  logic overflow_next;
  logic bad_frame_reg;
  logic bad_frame_next;
  logic good_frame_reg;
  logic good_frame_next;

  // The current pointer has run a full lap ahead of the read pointer.
  assign full_cur = (wr_ptr_cur_reg[ADDR_WIDTH] != rd_ptr_reg[ADDR_WIDTH]) &&
                    (wr_ptr_cur_reg[ADDR_WIDTH-1:0] == rd_ptr_reg[ADDR_WIDTH-1:0]);
  assign empty = (wr_ptr_reg == rd_ptr_reg);  // only committed frames are visible to the reader.

  assign s_ready = 1'b1;  // every beat is taken; a frame that does not fit is dropped instead.

  assign q_data = out_reg[DATA_WIDTH-1:0];
  assign q_last = out_reg[DATA_WIDTH];
  assign q_valid = out_valid_reg;

  assign status_overflow = overflow_reg;
  assign status_bad_frame = bad_frame_reg;
  assign status_good_frame = good_frame_reg;

  always_comb begin
    write = 1'b0;
    drop_frame_next = drop_frame_reg;
    overflow_next = 1'b0;
    bad_frame_next = 1'b0;
    good_frame_next = 1'b0;
    wr_ptr_next = wr_ptr_reg;
    wr_ptr_cur_next = wr_ptr_cur_reg;
    if (s_valid && s_ready) begin
      if (full_cur || drop_frame_reg) begin
        drop_frame_next = 1'b1;  // discard the rest of this frame.
        if (s_last) begin
          wr_ptr_cur_next = wr_ptr_reg;
          drop_frame_next = 1'b0;
          overflow_next = 1'b1;
        end
      end else begin
        write = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur_reg + 1'b1;
        if (s_last) begin
          if (s_user == USER_BAD_FRAME) begin
            wr_ptr_cur_next = wr_ptr_reg;  // rewind over the bad frame.
            bad_frame_next = 1'b1;
          end else begin
            wr_ptr_next = wr_ptr_cur_reg + 1'b1;
            good_frame_next = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_reg <= '0;
      wr_ptr_cur_reg <= '0;
      wr_addr_reg <= '0;
      drop_frame_reg <= 1'b0;
      overflow_reg <= 1'b0;
      bad_frame_reg <= 1'b0;
      good_frame_reg <= 1'b0;
    end else begin
      wr_ptr_reg <= wr_ptr_next;
      wr_ptr_cur_reg <= wr_ptr_cur_next;
      wr_addr_reg <= wr_ptr_cur_next;
      drop_frame_reg <= drop_frame_next;
      overflow_reg <= overflow_next;
      bad_frame_reg <= bad_frame_next;
      good_frame_reg <= good_frame_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_addr_reg[ADDR_WIDTH-1:0]] <= {s_last, s_data};
    end
  end

  // Read side: address register, memory register, output register.
  always_comb begin
    read = 1'b0;
    rd_ptr_next = rd_ptr_reg;
    mem_read_data_valid_next = mem_read_data_valid_reg;
    if (store_output || !mem_read_data_valid_reg) begin
      if (!empty) begin
        read = 1'b1;
        mem_read_data_valid_next = 1'b1;
        rd_ptr_next = rd_ptr_reg + 1'b1;
      end else begin
        mem_read_data_valid_next = 1'b0;
      end
    end
  end

  always_comb begin
    store_output = q_ready || !out_valid_reg;  // the output register holds under back-pressure.
    out_valid_next = out_valid_reg;
    if (store_output) begin
      out_valid_next = mem_read_data_valid_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_reg <= '0;
      rd_addr_reg <= '0;
      mem_read_data_valid_reg <= 1'b0;
      out_valid_reg <= 1'b0;
    end else begin
      rd_ptr_reg <= rd_ptr_next;
      rd_addr_reg <= rd_ptr_next;
      mem_read_data_valid_reg <= mem_read_data_valid_next;
      out_valid_reg <= out_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      mem_read_data_reg <= mem[rd_addr_reg[ADDR_WIDTH-1:0]];
    end
    if (store_output) begin
      out_reg <= mem_read_data_reg;
    end
  end

  // A write needs a free slot between the write address and the reader.
  a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    write |-> ((wr_addr_reg - rd_ptr_reg) != DEPTH))
    else $error("frame_fifo: memory write while the current pointer is full.");

  a_valid_held: assert property (@(posedge clk) disable iff (rst)
    q_valid && !q_ready |=> q_valid)
    else $error("frame_fifo: q_valid fell without a transfer.");

endmodule

`default_nettype wire

//--- dest_demux.sv
`timescale 1ns/100ps
`default_nettype none

module dest_demux #(
  parameter int NUM_PORTS = stream_pkg::NUM_PORTS_DEFAULT
) (
  input wire clk,
  input wire rst,
  input wire [stream_pkg::dest_width(NUM_PORTS)-1:0] s_dest,
  input wire s_valid,
  input wire s_last,
  input wire [NUM_PORTS-1:0] fifo_ready,
  output logic s_ready,
  output logic [NUM_PORTS-1:0] fifo_valid
);

  import stream_pkg::*;

  localparam int DEST_W = dest_width(NUM_PORTS);

  logic in_frame_reg;
  logic [DEST_W-1:0] dest_reg;
  logic [DEST_W-1:0] sel;
  logic [NUM_PORTS-1:0] sel_onehot;
  logic accept;

  // The first beat routes on s_dest directly; later beats follow the locked value.
  assign sel = in_frame_reg ? dest_reg : s_dest;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      sel_onehot[i] = (sel == DEST_W'(i));
    end
  end

  assign fifo_valid = sel_onehot & {NUM_PORTS{s_valid}};
  assign s_ready = |(sel_onehot & fifo_ready);
  assign accept = s_valid && s_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame_reg <= 1'b0;
    end else if (accept) begin
      in_frame_reg <= !s_last;  // cleared once the last beat is through.
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !in_frame_reg) begin
      dest_reg <= s_dest;
    end
  end

  a_dest_in_range: assert property (@(posedge clk) disable iff (rst)
    s_valid |-> (sel < NUM_PORTS))
    else $error("dest_demux: destination %0d has no queue.", sel);

endmodule

`default_nettype wire

//--- frame_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module frame_arbiter #(
  parameter int NUM_PORTS = stream_pkg::NUM_PORTS_DEFAULT,
  parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH_DEFAULT
) (
  input wire clk,
  input wire rst,
  input wire [NUM_PORTS-1:0][DATA_WIDTH-1:0] q_data,
  input wire [NUM_PORTS-1:0] q_last,
  input wire [NUM_PORTS-1:0] q_valid,
  output logic [NUM_PORTS-1:0] q_ready,
  output logic [DATA_WIDTH-1:0] m_data,
  output logic m_last,
  output logic [stream_pkg::dest_width(NUM_PORTS)-1:0] m_dest,
  output logic m_valid,
  input wire m_ready
);

  import stream_pkg::*;

  localparam int DEST_W = dest_width(NUM_PORTS);
  localparam logic [DEST_W-1:0] LAST_INDEX = DEST_W'(NUM_PORTS - 1);

  logic [DEST_W-1:0] grant_reg;
  logic in_frame_reg;
  logic [DEST_W-1:0] found_idx;
  logic found;
  logic [DEST_W-1:0] sel;

  // Round-robin search, starting one past the previous grant and ending on it.
  always_comb begin : search
    int idx;
    found = 1'b0;
    found_idx = grant_reg;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      idx = (int'(grant_reg) + k) % NUM_PORTS;
      if (!found && q_valid[idx]) begin
        found = 1'b1;
        found_idx = DEST_W'(idx);
      end
    end
  end

  assign sel = in_frame_reg ? grant_reg : found_idx;

  // With nothing valid the search falls back to grant_reg, whose q_valid is then low.
  assign m_valid = q_valid[sel];
  assign m_data = q_data[sel];
  assign m_last = q_last[sel];
  assign m_dest = sel;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      q_ready[i] = m_ready && (sel == DEST_W'(i));
    end
  end

  // Lock as soon as a beat is offered so the egress beat cannot switch queues under it.
  always_ff @(posedge clk) begin
    if (rst) begin
      grant_reg <= LAST_INDEX;  // the first search after reset starts at queue 0.
      in_frame_reg <= 1'b0;
    end else if (m_valid) begin
      grant_reg <= sel;
      in_frame_reg <= !(m_ready && m_last);
    end
  end

  a_grant_locked: assert property (@(posedge clk) disable iff (rst)
    in_frame_reg |=> $stable(grant_reg))
    else $error("frame_arbiter: grant moved in the middle of a frame.");

  a_egress_held: assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_dest) && $stable(m_data))
    else $error("frame_arbiter: egress beat changed before its transfer.");

endmodule

`default_nettype wire

//--- stream_frame_switch.sv
`timescale 1ns/100ps
`default_nettype none

module stream_frame_switch #(
  parameter int NUM_PORTS = stream_pkg::NUM_PORTS_DEFAULT,
  parameter int ADDR_WIDTH = stream_pkg::ADDR_WIDTH_DEFAULT,
  parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH_DEFAULT
) (
  input wire clk,
  input wire rst,
  input wire [DATA_WIDTH-1:0] s_data,
  input wire s_last,
  input wire s_user,
  input wire [stream_pkg::dest_width(NUM_PORTS)-1:0] s_dest,
  input wire s_valid,
  output wire s_ready,
  output wire [DATA_WIDTH-1:0] m_data,
  output wire m_last,
  output wire [stream_pkg::dest_width(NUM_PORTS)-1:0] m_dest,
  output wire m_valid,
  input wire m_ready,
  output wire [NUM_PORTS-1:0] status_overflow,
  output wire [NUM_PORTS-1:0] status_bad_frame,
  output wire [NUM_PORTS-1:0] status_good_frame
);

  wire [NUM_PORTS-1:0] fifo_valid;
  wire [NUM_PORTS-1:0] fifo_ready;
  wire [NUM_PORTS-1:0][DATA_WIDTH-1:0] q_data;
  wire [NUM_PORTS-1:0] q_last;
  wire [NUM_PORTS-1:0] q_valid;
  wire [NUM_PORTS-1:0] q_ready;

  dest_demux #(
    .NUM_PORTS(NUM_PORTS)
  ) u_demux (
    .clk(clk),
    .rst(rst),
    .s_dest(s_dest),
    .s_valid(s_valid),
    .s_last(s_last),
    .fifo_ready(fifo_ready),
    .s_ready(s_ready),
    .fifo_valid(fifo_valid)
  );

  // Data, last and user go to every queue; only the selected one sees valid.
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_queue
    frame_fifo #(
      .ADDR_WIDTH(ADDR_WIDTH),
      .DATA_WIDTH(DATA_WIDTH)
    ) u_fifo (
      .clk(clk),
      .rst(rst),
      .s_data(s_data),
      .s_last(s_last),
      .s_user(s_user),
      .s_valid(fifo_valid[i]),
      .s_ready(fifo_ready[i]),
      .q_data(q_data[i]),
      .q_last(q_last[i]),
      .q_valid(q_valid[i]),
      .q_ready(q_ready[i]),
      .status_overflow(status_overflow[i]),
      .status_bad_frame(status_bad_frame[i]),
      .status_good_frame(status_good_frame[i])
    );
  end

  frame_arbiter #(
    .NUM_PORTS(NUM_PORTS),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_arbiter (
    .clk(clk),
    .rst(rst),
    .q_data(q_data),
    .q_last(q_last),
    .q_valid(q_valid),
    .q_ready(q_ready),
    .m_data(m_data),
    .m_last(m_last),
    .m_dest(m_dest),
    .m_valid(m_valid),
    .m_ready(m_ready)
  );

endmodule

`default_nettype wire

//--- tb_frame_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_frame_checker #(
  parameter int NUM_PORTS = 4,
  parameter int DEST_W = 2
) (
  input wire clk,
  input wire rst,
  input wire [7:0] s_data,
  input wire s_last,
  input wire [DEST_W-1:0] s_dest,
  input wire s_valid,
  input wire s_ready,
  input wire [7:0] m_data,
  input wire m_last,
  input wire [DEST_W-1:0] m_dest,
  input wire m_valid,
  input wire m_ready,
  input wire [NUM_PORTS-1:0] status_overflow,
  input wire [NUM_PORTS-1:0] status_bad_frame,
  input wire [NUM_PORTS-1:0] status_good_frame,
  input wire [127:0] test_name,
  input wire [1:0] fate,
  input wire rr_test,
  output int pending,
  output int pass_count,
  output int fail_count
);

  // Frames still expected at egress, oldest first.
  int exp_dest[$];
  int exp_len[$];
  logic [127:0] exp_name[$];
  logic [127:0] exp_bytes[$];
  logic exp_rr[$];

  logic [127:0] in_bytes;
  int in_cnt;
  int in_dest;
  logic lat_valid;
  int lat_dest;
  int lat_fate;
  logic [127:0] lat_name;
  int out_idx;
  int out_cnt;
  logic out_err;
  int rr_prev;
  logic prev_rst;

  task automatic report_mismatch(input logic [127:0] name, input string what,
                                 input int expected, input int actual);
    $display("MISMATCH %0s %0s: expected %0h, actual %0h", name, what, expected, actual);
    fail_count++;
  endtask

  task automatic report_error(input string text);
    $display("ERROR: %0s", text);
    fail_count++;
  endtask

  initial begin
    pending = 0;
    pass_count = 0;
    fail_count = 0;
    prev_rst = 1'b1;
  end

  // All DUT signals are sampled at the falling edge, half a cycle away from any change.
  always @(negedge clk) begin : watch
    logic [NUM_PORTS-1:0] one_hot;
    logic [3*NUM_PORTS-1:0] exp_status;
    if (rst) begin
      in_cnt = 0;
      lat_valid = 1'b0;
      out_cnt = 0;
      out_idx = -1;
      out_err = 1'b0;
      rr_prev = -1;
    end else begin
      if (prev_rst && (!s_ready || m_valid)) begin
        report_error("s_ready low or m_valid high right after reset");
      end
      one_hot = NUM_PORTS'(1) << lat_dest;
      exp_status = '0;
      if (lat_valid) begin
        exp_status = {(lat_fate == 2) ? one_hot : '0, (lat_fate == 1) ? one_hot : '0,
                      (lat_fate == 0) ? one_hot : '0};
      end
      if ({status_overflow, status_bad_frame, status_good_frame} !== exp_status) begin
        report_mismatch(lat_valid ? lat_name : "(no frame)", "status {ovf,bad,good}",
                        int'(exp_status), int'({status_overflow, status_bad_frame,
                                                status_good_frame}));
      end else if (lat_valid && lat_fate != 0) begin
        $display("PASS %0s: dropped on queue %0d", lat_name, lat_dest);
        pass_count++;
      end
      lat_valid = 1'b0;

      if (s_valid && !s_ready && fate == 2) begin
        report_error("ingress stalled during a frame that should overflow");
      end
      if (s_valid && s_ready) begin
        if (in_cnt == 0) begin
          in_dest = int'(s_dest);
        end
        if (in_cnt < 16) begin
          in_bytes[8*in_cnt +: 8] = s_data;
        end
        in_cnt++;
        if (s_last) begin
          lat_valid = 1'b1;  // status pulse is due on the next cycle.
          lat_dest = in_dest;
          lat_fate = int'(fate);
          lat_name = test_name;
          if (fate == 0) begin
            exp_dest.push_back(in_dest);
            exp_len.push_back(in_cnt);
            exp_name.push_back(test_name);
            exp_bytes.push_back(in_bytes);
            exp_rr.push_back(rr_test);
            pending++;
          end
          in_cnt = 0;
        end
      end

      if (m_valid && m_ready) begin
        if (out_cnt == 0) begin
          out_err = 1'b0;
          out_idx = -1;
          for (int k = 0; k < exp_dest.size(); k++) begin
            if (out_idx < 0 && exp_dest[k] == int'(m_dest)) begin
              out_idx = k;  // oldest good frame for this queue.
            end
          end
          if (out_idx < 0) begin
            report_error($sformatf("frame on egress dest %0d with no good frame pending",
                                   m_dest));
          end
        end
        if (out_idx >= 0) begin
          if (out_cnt >= exp_len[out_idx]) begin
            report_mismatch(exp_name[out_idx], "frame length", exp_len[out_idx], out_cnt + 1);
            out_err = 1'b1;
          end else if (m_data !== exp_bytes[out_idx][8*out_cnt +: 8]) begin
            report_mismatch(exp_name[out_idx], $sformatf("data beat %0d", out_cnt),
                            exp_bytes[out_idx][8*out_cnt +: 8], m_data);
            out_err = 1'b1;
          end
          if (m_last !== (out_cnt == exp_len[out_idx] - 1)) begin
            report_mismatch(exp_name[out_idx], $sformatf("last beat %0d", out_cnt),
                            out_cnt == exp_len[out_idx] - 1, m_last);
            out_err = 1'b1;
          end
        end
        out_cnt++;
        if (m_last) begin
          if (out_idx >= 0) begin
            if (exp_rr[out_idx]) begin
              if (rr_prev >= 0 && int'(m_dest) != (rr_prev + 1) % NUM_PORTS) begin
                report_error($sformatf("round-robin order broken, queue %0d after queue %0d",
                                       m_dest, rr_prev));
                out_err = 1'b1;
              end
              rr_prev = int'(m_dest);
            end
            if (!out_err) begin
              $display("PASS %0s: %0d bytes on dest %0d", exp_name[out_idx], out_cnt, m_dest);
              pass_count++;
            end else begin
              $display("FAIL %0s: frame on dest %0d differs", exp_name[out_idx], m_dest);
            end
            exp_dest.delete(out_idx);
            exp_len.delete(out_idx);
            exp_name.delete(out_idx);
            exp_bytes.delete(out_idx);
            exp_rr.delete(out_idx);
            pending--;
          end
          out_cnt = 0;
        end
      end
    end
    prev_rst = rst;
  end

endmodule

`default_nettype wire

//--- tb_stream_frame_switch.sv
`timescale 1ns/100ps
`default_nettype none

module tb_stream_frame_switch;

  import stream_pkg::*;

  localparam int NUM_PORTS = NUM_PORTS_DEFAULT;
  localparam int DEST_W = dest_width(NUM_PORTS);
  localparam int MODE_HOLD = 0;
  localparam int MODE_RAND = 1;
  localparam int MODE_OPEN = 2;

  logic clk;
  logic rst;
  logic [7:0] s_data;
  logic s_last;
  logic s_user;
  logic [DEST_W-1:0] s_dest;
  logic s_valid;
  wire s_ready;
  wire [7:0] m_data;
  wire m_last;
  wire [DEST_W-1:0] m_dest;
  wire m_valid;
  logic m_ready;
  wire [NUM_PORTS-1:0] status_overflow;
  wire [NUM_PORTS-1:0] status_bad_frame;
  wire [NUM_PORTS-1:0] status_good_frame;

  logic [127:0] test_name;
  logic [1:0] fate;
  logic rr_test;
  int pending;
  int pass_count;
  int fail_count;
  int ready_mode;
  logic [15:0] lfsr;
  int limit_cycles;

  // One entry per golden line.
  logic [127:0] names[$];
  int dests[$];
  int bads[$];
  int lens[$];
  int fates[$];
  logic [255:0] datas[$];
  logic holds[$];
  logic rrs[$];

  stream_frame_switch #(
    .NUM_PORTS(NUM_PORTS),
    .ADDR_WIDTH(ADDR_WIDTH_DEFAULT),
    .DATA_WIDTH(DATA_WIDTH_DEFAULT)
  ) uut (
    .clk(clk), .rst(rst),
    .s_data(s_data), .s_last(s_last), .s_user(s_user), .s_dest(s_dest),
    .s_valid(s_valid), .s_ready(s_ready),
    .m_data(m_data), .m_last(m_last), .m_dest(m_dest), .m_valid(m_valid), .m_ready(m_ready),
    .status_overflow(status_overflow), .status_bad_frame(status_bad_frame),
    .status_good_frame(status_good_frame)
  );

  tb_frame_checker #(
    .NUM_PORTS(NUM_PORTS),
    .DEST_W(DEST_W)
  ) u_check (
    .clk(clk), .rst(rst),
    .s_data(s_data), .s_last(s_last), .s_dest(s_dest), .s_valid(s_valid), .s_ready(s_ready),
    .m_data(m_data), .m_last(m_last), .m_dest(m_dest), .m_valid(m_valid), .m_ready(m_ready),
    .status_overflow(status_overflow), .status_bad_frame(status_bad_frame),
    .status_good_frame(status_good_frame),
    .test_name(test_name), .fate(fate), .rr_test(rr_test),
    .pending(pending), .pass_count(pass_count), .fail_count(fail_count)
  );

  always #20 clk = ~clk;

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  always @(posedge clk) begin
    #2;
    if (ready_mode == MODE_HOLD) begin
      m_ready = 1'b0;
    end else if (ready_mode == MODE_RAND) begin
      m_ready = lfsr[15];
      lfsr = lfsr_next(lfsr);
    end else begin
      m_ready = 1'b1;
    end
  end

  task automatic send_frame(input int dest, input int bad, input int len,
                            input logic [255:0] bytes);
    logic taken;
    for (int i = 0; i < len; i++) begin
      s_data = bytes[8*i +: 8];
      s_last = (i == len - 1);
      s_user = (bad != 0) && (i == len - 1);  // the bad mark only counts on the last beat.
      s_dest = DEST_W'(dest);
      s_valid = 1'b1;
      taken = 1'b0;
      while (!taken) begin
        @(negedge clk);
        taken = s_ready;
        @(posedge clk);
        #2;
      end
    end
    s_valid = 1'b0;
    s_last = 1'b0;
    s_user = 1'b0;
  endtask

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("TIMEOUT: run still busy after %0d cycles", limit_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main
    int fd;
    int code;
    int d;
    int b;
    int n;
    int total_beats;
    string tok;
    string fstr;
    string line;
    logic [7:0] byte_v;
    logic [255:0] data;
    logic [127:0] name_v;
    logic prev_hold;
    clk = 1'b0;
    rst = 1'b1;
    s_data = '0;
    s_last = 1'b0;
    s_user = 1'b0;
    s_dest = '0;
    s_valid = 1'b0;
    m_ready = 1'b0;
    ready_mode = MODE_HOLD;
    lfsr = 16'd3057;
    limit_cycles = 0;
    test_name = '0;
    fate = '0;
    rr_test = 1'b0;
    total_beats = 0;
    prev_hold = 1'b0;

    fd = $fopen("golden_frames.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open golden_frames.txt");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        tok = "";
        code = $fscanf(fd, "%s", tok);
        if (code == 1 && tok.substr(0, 0) == "#") begin
          code = $fgets(line, fd);  // skip the rest of a comment line.
        end else if (code == 1) begin
          code = $fscanf(fd, "%d %d %d %s", d, b, n, fstr);
          data = '0;
          for (int i = 0; i < n; i++) begin
            code = $fscanf(fd, "%h", byte_v);
            data[8*i +: 8] = byte_v;
          end
          code = $sscanf(tok, "%s", name_v);
          names.push_back(name_v);
          dests.push_back(d);
          bads.push_back(b);
          lens.push_back(n);
          fates.push_back((fstr == "good") ? 0 : ((fstr == "bad") ? 1 : 2));
          datas.push_back(data);
          holds.push_back(tok.substr(0, 1) == "rr" || tok.substr(0, 4) == "stall");
          rrs.push_back(tok.substr(0, 1) == "rr");
          total_beats += n;
        end
      end
      $fclose(fd);
    end
    limit_cycles = total_beats * 8 + 400;

    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    for (int k = 0; k < names.size(); k++) begin
      if (holds[k] && !prev_hold) begin
        ready_mode = MODE_RAND;
        wait (pending == 0);  // a stall phase starts from empty queues.
      end
      if (!holds[k]) begin
        ready_mode = MODE_RAND;
        wait (pending <= 1);  // keeps random back-pressure from filling a queue.
      end else begin
        ready_mode = MODE_HOLD;
      end
      @(posedge clk);
      #2;
      test_name = names[k];
      fate = 2'(fates[k]);
      rr_test = rrs[k];
      send_frame(dests[k], bads[k], lens[k], datas[k]);
      prev_hold = holds[k];
    end

    ready_mode = MODE_OPEN;
    wait (pending == 0);
    repeat (10) @(posedge clk);
    $display("tests passed: %0d, failed checks: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- golden_frames.txt
# columns: test name, destination, bad flag, length, expected fate (good, bad or overflow),
# then one data byte in hex per beat. stall and rr tests hold m_ready low.
basic_q0 0 0 4 good 10 11 12 13
basic_q1 1 0 3 good 20 21 22
basic_q2 2 0 5 good 30 31 32 33 34
basic_q3 3 0 2 good 40 41
order_q1_a 1 0 6 good 50 51 52 53 54 55
order_q1_b 1 0 4 good 58 59 5a 5b
bad_q2 2 1 5 bad 60 61 62 63 64
after_bad_q2 2 0 3 good 68 69 6a
long_q1 1 0 20 overflow 70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d 7e 7f 80 81 82 83
after_long_q1 1 0 4 good 88 89 8a 8b
rand_mix_q3 3 0 8 good 90 91 92 93 94 95 96 97
rand_mix_q0 0 0 7 good a0 a1 a2 a3 a4 a5 a6
bad_q0 0 1 1 bad a8
stall_fill_q2 2 0 12 good b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb
stall_over_q2 2 0 8 overflow c0 c1 c2 c3 c4 c5 c6 c7
rand_after_q0 0 0 5 good d0 d1 d2 d3 d4
rr_q0 0 0 4 good e0 e1 e2 e3
rr_q1 1 0 4 good e4 e5 e6 e7
rr_q2 2 0 4 good e8 e9 ea eb
rr_q3 3 0 4 good ec ed ee ef

//--- all.f
stream_pkg.sv
frame_fifo.sv
dest_demux.sv
frame_arbiter.sv
stream_frame_switch.sv
tb_frame_checker.sv
tb_stream_frame_switch.sv

//--- Bender.yml
package:
  name: stream_frame_switch

sources:
  - stream_pkg.sv
  - frame_fifo.sv
  - dest_demux.sv
  - frame_arbiter.sv
  - stream_frame_switch.sv
  - target: test
    files:
      - tb_frame_checker.sv
      - tb_stream_frame_switch.sv
